// ==== ddr_stat_bridge.f ====
logic/ddr_stat_pkg.sv
logic/rst_flr_ctrl.sv
logic/cfg_pipe.sv
logic/stat_regs.sv
logic/ddr_stat_bridge.sv
testbench/tb_ddr_stat_bridge.sv

// ==== Makefile ====
VERILATOR  ?= verilator
VFLAGS     = --binary --timing --assert
LINT_FLAGS = --lint-only -Wall --timing
TOP        = tb_ddr_stat_bridge
FILELIST   = ddr_stat_bridge.f
BUILD_DIR  = obj_dir
LOG        = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)

run: build
	./$(BUILD_DIR)/$(TOP) > $(LOG) 2>&1 ; cat $(LOG)
	@if grep -q "TEST FAIL" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@if ! grep -q "TEST PASS" $(LOG); then echo "simulation ended early"; exit 1; fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== testbench/tb_ddr_stat_bridge.sv ====
// DDR status bridge testbench

`timescale 1ns/100ps

module tb_ddr_stat_bridge;

   import ddr_stat_pkg::*;

   localparam int ACK_LATENCY  = 17;
   localparam int FLR_LATENCY  = 2;
   localparam int ACK_TIMEOUT  = 100;
   localparam int FLR_WINDOW   = 10;
   localparam int QUIET_CYCLES = 20;
   localparam int RESET_CYCLES = 16;
   localparam int MAX_ENTRIES  = 32;

   typedef enum logic [1:0] {OP_IDLE, OP_WRITE, OP_READ} op_e;

   // One row of the stimulus table, expected fields come from the model
   typedef struct {
      string      name;
      op_e        op;
      stat_addr_t addr;
      stat_data_t wdata;
      logic       rand_data;
      stat_data_t exp_rdata;
      stat_int_t  exp_intr;
   } entry_t;

   logic      clk_main_a0 = 1'b0;
   logic      rst_main_n;
   logic      sh_cl_flr_assert;
   logic      cl_sh_flr_done;
   stat_req_t stat_req;
   stat_ack_t stat_ack;

   entry_t    tbl [MAX_ENTRIES];
   int        num_entries;
   int        pending_idx [$];
   int        pending_cyc [$];
   integer    seed = 32'h22d;
   int        pass_count;
   int        fail_count;
   int        other_errors;

   ddr_stat_bridge ddr_stat_bridge_i (
      .clk_main_a0      (clk_main_a0),
      .rst_main_n       (rst_main_n),
      .sh_cl_flr_assert (sh_cl_flr_assert),
      .cl_sh_flr_done   (cl_sh_flr_done),
      .stat_req         (stat_req),
      .stat_ack         (stat_ack)
   );

   always #10 clk_main_a0 = ~clk_main_a0;

   //////////////////////////////////////////////////
   // Stimulus table
   //////////////////////////////////////////////////

   task automatic add_entry(input string name, input op_e op, input stat_addr_t addr,
                            input stat_data_t wdata, input logic rand_data);
      tbl[num_entries].name      = name;
      tbl[num_entries].op        = op;
      tbl[num_entries].addr      = addr;
      tbl[num_entries].wdata     = wdata;
      tbl[num_entries].rand_data = rand_data;
      tbl[num_entries].exp_rdata = '0;
      tbl[num_entries].exp_intr  = '0;
      num_entries++;
   endtask

   task automatic build_table();
      num_entries = 0;
      // Fresh registers read as zero
      add_entry("rd_reset_r0",     OP_READ,  8'd0,   32'h0, 1'b0);
      add_entry("rd_reset_r5",     OP_READ,  8'd5,   32'h0, 1'b0);
      add_entry("rd_reset_r15",    OP_READ,  8'd15,  32'h0, 1'b0);
      // Write and read back, issued back to back
      add_entry("wr_r1",           OP_WRITE, 8'd1,   32'h1234_5678, 1'b0);
      add_entry("wr_r7",           OP_WRITE, 8'd7,   32'h0, 1'b1);
      add_entry("wr_r15",          OP_WRITE, 8'd15,  32'hdead_beef, 1'b0);
      add_entry("idle",            OP_IDLE,  8'd0,   32'h0, 1'b0);
      add_entry("rd_back_r1",      OP_READ,  8'd1,   32'h0, 1'b0);
      add_entry("rd_back_r7",      OP_READ,  8'd7,   32'h0, 1'b0);
      add_entry("rd_back_r15",     OP_READ,  8'd15,  32'h0, 1'b0);
      // Out of range, 16 aliases register 0 in its low bits
      add_entry("wr_oor_16",       OP_WRITE, 8'd16,  32'h0, 1'b1);
      add_entry("wr_oor_ff",       OP_WRITE, 8'd255, 32'h5a5a_5a5a, 1'b0);
      add_entry("rd_oor_16",       OP_READ,  8'd16,  32'h0, 1'b0);
      add_entry("rd_oor_ff",       OP_READ,  8'd255, 32'h0, 1'b0);
      add_entry("rd_after_oor_r0", OP_READ,  8'd0,   32'h0, 1'b0);
      add_entry("rd_after_oor_r15", OP_READ, 8'd15,  32'h0, 1'b0);
      // Interrupt vector follows register 0
      add_entry("wr_r0",           OP_WRITE, 8'd0,   32'h0, 1'b1);
      add_entry("rd_intr_r3",      OP_READ,  8'd3,   32'h0, 1'b0);
      add_entry("idle",            OP_IDLE,  8'd0,   32'h0, 1'b0);
      add_entry("idle",            OP_IDLE,  8'd0,   32'h0, 1'b0);
      add_entry("wr_r2",           OP_WRITE, 8'd2,   32'h0bad_f00d, 1'b0);
      add_entry("wr_r0_again",     OP_WRITE, 8'd0,   32'h0000_00c3, 1'b0);
      add_entry("rd_back_r0",      OP_READ,  8'd0,   32'h0, 1'b0);
      // Read right behind its write
      add_entry("wr_r9",           OP_WRITE, 8'd9,   32'h0, 1'b1);
      add_entry("rd_back_r9",      OP_READ,  8'd9,   32'h0, 1'b0);
      add_entry("rd_back_r2",      OP_READ,  8'd2,   32'h0, 1'b0);
   endtask

   // Reference model of the register file, acks return in request order
   task automatic build_expected();
      stat_data_t ref_regs [NUM_STAT_REGS];
      int         a;
      for (int r = 0; r < NUM_STAT_REGS; r++)
         ref_regs[r] = '0;
      for (int i = 0; i < num_entries; i++)
      begin
         if (tbl[i].rand_data)
            tbl[i].wdata = $random(seed);
         a = int'(tbl[i].addr);
         tbl[i].exp_rdata = '0;
         if (tbl[i].op == OP_WRITE && a < NUM_STAT_REGS)
            ref_regs[a] = tbl[i].wdata;
         if (tbl[i].op == OP_READ && a < NUM_STAT_REGS)
            tbl[i].exp_rdata = ref_regs[a];
         tbl[i].exp_intr = ref_regs[0][STAT_INT_W-1:0];
      end
   endtask

   //////////////////////////////////////////////////
   // Checking
   //////////////////////////////////////////////////

   task automatic report_test(input string name, input bit ok);
      if (ok)
      begin
         $display("%s passed", name);
         pass_count++;
      end
      else
      begin
         $display("%s failed", name);
         fail_count++;
      end
   endtask

   // Sampled 1 ns after the edge, when the outputs are settled
   task automatic check_ack(input int cyc);
      int idx;
      int issued;
      bit ok;
      assert (cl_sh_flr_done === 1'b0)
      else
      begin
         $display("function-level reset done went high with no request, cycle %0d", cyc);
         other_errors++;
      end
      if (stat_ack.ack === 1'b1)
      begin
         if (pending_idx.size() == 0)
         begin
            $display("status ack arrived with no request outstanding, cycle %0d", cyc);
            other_errors++;
         end
         else
         begin
            idx    = pending_idx.pop_front();
            issued = pending_cyc.pop_front();
            ok     = 1'b1;
            assert (cyc - issued == ACK_LATENCY)
            else
            begin
               $display("error %s: latency expected %0d actual %0d",
                        tbl[idx].name, ACK_LATENCY, cyc - issued);
               ok = 1'b0;
            end
            assert (stat_ack.rdata === tbl[idx].exp_rdata)
            else
            begin
               $display("error %s: rdata expected %h actual %h",
                        tbl[idx].name, tbl[idx].exp_rdata, stat_ack.rdata);
               ok = 1'b0;
            end
            assert (stat_ack.intr === tbl[idx].exp_intr)
            else
            begin
               $display("error %s: intr expected %h actual %h",
                        tbl[idx].name, tbl[idx].exp_intr, stat_ack.intr);
               ok = 1'b0;
            end
            report_test(tbl[idx].name, ok);
         end
      end
   endtask

   //////////////////////////////////////////////////
   // Test phases
   //////////////////////////////////////////////////

   task automatic apply_reset();
      bit ok;
      ok = 1'b1;
      // Sync chain and pipelines need a few edges before they settle
      for (int i = 0; i < RESET_CYCLES + 8; i++)
      begin
         @(posedge clk_main_a0);
         #1;
         if (i >= 8)
         begin
            assert (stat_ack.ack === 1'b0)
            else
            begin
               $display("error reset_outputs_low: ack expected 0 actual %b", stat_ack.ack);
               ok = 1'b0;
            end
            assert (cl_sh_flr_done === 1'b0)
            else
            begin
               $display("error reset_outputs_low: flr done expected 0 actual %b",
                        cl_sh_flr_done);
               ok = 1'b0;
            end
         end
         if (i == RESET_CYCLES - 1)
            rst_main_n = 1'b1;
      end
      report_test("reset_outputs_low", ok);
   endtask

   task automatic run_table();
      int cyc;
      int next;
      int idle_wait;
      cyc       = 0;
      next      = 0;
      idle_wait = 0;
      while ((next < num_entries || pending_idx.size() > 0) && idle_wait < ACK_TIMEOUT)
      begin
         @(posedge clk_main_a0);
         #1;
         cyc++;
         check_ack(cyc);
         stat_req = '0;
         if (next < num_entries)
         begin
            stat_req.wr    = (tbl[next].op == OP_WRITE);
            stat_req.rd    = (tbl[next].op == OP_READ);
            stat_req.addr  = tbl[next].addr;
            stat_req.wdata = tbl[next].wdata;
            if (tbl[next].op != OP_IDLE)
            begin
               pending_idx.push_back(next);
               pending_cyc.push_back(cyc);
            end
            next++;
         end
         else
            idle_wait++;
      end
      if (pending_idx.size() > 0)
      begin
         $display("timed out waiting for %0d status acks", pending_idx.size());
         other_errors++;
      end
      // Stray acks would show up here
      for (int q = 0; q < QUIET_CYCLES; q++)
      begin
         @(posedge clk_main_a0);
         #1;
         cyc++;
         check_ack(cyc);
      end
   endtask

   task automatic flr_check();
      int pulses;
      int first_lat;
      pulses    = 0;
      first_lat = -1;
      @(posedge clk_main_a0);
      #1;
      sh_cl_flr_assert = 1'b1;
      for (int lat = 1; lat <= FLR_WINDOW; lat++)
      begin
         @(posedge clk_main_a0);
         #1;
         sh_cl_flr_assert = 1'b0;
         if (cl_sh_flr_done === 1'b1)
         begin
            pulses++;
            if (first_lat < 0)
               first_lat = lat;
         end
      end
      if (pulses == 0)
      begin
         $display("function-level reset done never arrived within %0d cycles", FLR_WINDOW);
         other_errors++;
      end
      assert (pulses == 1 && first_lat == FLR_LATENCY)
      else
         $display("error flr_single_pulse: pulses/latency expected 1/%0d actual %0d/%0d",
                  FLR_LATENCY, pulses, first_lat);
      report_test("flr_single_pulse", pulses == 1 && first_lat == FLR_LATENCY);
   endtask

   initial
   begin
      rst_main_n       = 1'b0;
      sh_cl_flr_assert = 1'b0;
      stat_req         = '0;
      pass_count       = 0;
      fail_count       = 0;
      other_errors     = 0;
      build_table();
      build_expected();
      apply_reset();
      run_table();
      flr_check();
      $display("summary: %0d passed, %0d failed, %0d other errors",
               pass_count, fail_count, other_errors);
      if (fail_count == 0 && other_errors == 0)
         $display("TEST PASS");
      else
         $display("TEST FAIL");
      $finish;
   end

endmodule

// ==== logic/ddr_stat_bridge.sv ====
// DDR status bridge top level

`timescale 1ns/100ps

module ddr_stat_bridge
(
   input  logic                    clk_main_a0,
   input  logic                    rst_main_n,

   input  logic                    sh_cl_flr_assert,
   output logic                    cl_sh_flr_done,

   input  ddr_stat_pkg::stat_req_t stat_req,
   output ddr_stat_pkg::stat_ack_t stat_ack
);

   import ddr_stat_pkg::*;

   logic                  clk;
   logic                  pipe_rst_n;

   // Flat views of the status structs around the pipelines
   logic [STAT_REQ_W-1:0] req_flat;
   logic [STAT_REQ_W-1:0] req_flat_q;
   logic [STAT_ACK_W-1:0] ack_flat;
   logic [STAT_ACK_W-1:0] ack_flat_q;

   stat_req_t             req_q;
   stat_ack_t             rsp;

   assign clk = clk_main_a0;

   //////////////////////////////////////////////////
   // Reset and FLR
   //////////////////////////////////////////////////

   rst_flr_ctrl rst_flr_ctrl_i (
      .clk              (clk),
      .rst_main_n       (rst_main_n),
      .sh_cl_flr_assert (sh_cl_flr_assert),
      .pipe_rst_n       (pipe_rst_n),
      .cl_sh_flr_done   (cl_sh_flr_done)
   );

   //////////////////////////////////////////////////
   // Status request path
   //////////////////////////////////////////////////

   assign req_flat = stat_req;

   cfg_pipe #(.WIDTH(STAT_REQ_W), .STAGES(NUM_CFG_STGS)) pipe_stat_req_i (
      .clk        (clk),
      .pipe_rst_n (pipe_rst_n),
      .in_bus     (req_flat),
      .out_bus    (req_flat_q)
   );

   assign req_q = stat_req_t'(req_flat_q);

   stat_regs stat_regs_i (
      .clk        (clk),
      .pipe_rst_n (pipe_rst_n),
      .req        (req_q),
      .rsp        (rsp)
   );

   //////////////////////////////////////////////////
   // Status ack path
   //////////////////////////////////////////////////

   assign ack_flat = rsp;

   cfg_pipe #(.WIDTH(STAT_ACK_W), .STAGES(NUM_CFG_STGS)) pipe_stat_ack_i (
      .clk        (clk),
      .pipe_rst_n (pipe_rst_n),
      .in_bus     (ack_flat),
      .out_bus    (ack_flat_q)
   );

   assign stat_ack = stat_ack_t'(ack_flat_q);

endmodule

// ==== logic/stat_regs.sv ====
// DDR status register target

`timescale 1ns/100ps

module stat_regs
(
   input  logic                    clk,
   input  logic                    pipe_rst_n,
   input  ddr_stat_pkg::stat_req_t req,
   output ddr_stat_pkg::stat_ack_t rsp
);

   import ddr_stat_pkg::*;

   stat_data_t            regs_q [NUM_STAT_REGS];
   logic                  in_range;
   logic [STAT_IDX_W-1:0] idx;
   logic                  wr_hit;
   stat_data_t            reg0_nxt;
   stat_data_t            rd_word;

   //////////////////////////////////////////////////
   // Address decode
   //////////////////////////////////////////////////

   // Addresses past the last register are acked but never stored
   assign in_range = req.addr < stat_addr_t'(NUM_STAT_REGS);
   assign idx      = req.addr[STAT_IDX_W-1:0];
   assign wr_hit   = req.wr && in_range;

   // Register 0 as it looks once this request has been applied
   always_comb
   begin
      reg0_nxt = regs_q[0];
      if (wr_hit && (idx == '0))
         reg0_nxt = req.wdata;
   end

   // Read data is zero for writes and for out-of-range reads
   always_comb
   begin
      rd_word = '0;
      if (req.rd && in_range)
         rd_word = regs_q[idx];
   end

   //////////////////////////////////////////////////
   // Register file and ack
   //////////////////////////////////////////////////

   always_ff @(posedge clk)
   begin
      if (!pipe_rst_n)
      begin
         for (int i = 0; i < NUM_STAT_REGS; i++)
            regs_q[i] <= '0;
         rsp <= '0;
      end
      else
      begin
         if (wr_hit)
            regs_q[idx] <= req.wdata;

         // One ack per strobe, issued on the following cycle
         rsp.ack   <= req.wr | req.rd;
         rsp.intr  <= reg0_nxt[STAT_INT_W-1:0];
         rsp.rdata <= rd_word;
      end
   end

   // The host side never issues a write and a read together
   one_strobe: assert property (
      @(posedge clk) disable iff (!pipe_rst_n)
      !(req.wr && req.rd)
   )
   else
      $error("status wr and rd strobes high in the same cycle");

endmodule

// ==== logic/cfg_pipe.sv ====
// Configuration register pipeline

`timescale 1ns/100ps

module cfg_pipe
#(
   parameter int WIDTH  = ddr_stat_pkg::STAT_REQ_W,
   parameter int STAGES = ddr_stat_pkg::NUM_CFG_STGS
)
(
   input  logic             clk,
   input  logic             pipe_rst_n,
   input  logic [WIDTH-1:0] in_bus,
   output logic [WIDTH-1:0] out_bus
);

   import ddr_stat_pkg::*;

   // One entry per stage, entry 0 is closest to the input
   logic [WIDTH-1:0] stg_q [STAGES];

   //////////////////////////////////////////////////
   // Stage chain
   //////////////////////////////////////////////////

   // Every stage holds its own item, so a new one may enter
   // each cycle while older ones are still moving through
   always_ff @(posedge clk)
   begin
      if (!pipe_rst_n)
      begin
         for (int i = 0; i < STAGES; i++)
            stg_q[i] <= '0;
      end
      else
      begin
         stg_q[0] <= in_bus;
         for (int i = 1; i < STAGES; i++)
            stg_q[i] <= stg_q[i-1];
      end
   end

   // Last stage drives the far side directly, no logic after it
   assign out_bus = stg_q[STAGES-1];

endmodule

// ==== logic/rst_flr_ctrl.sv ====
// Reset pipeline and FLR response

`timescale 1ns/100ps

module rst_flr_ctrl
(
   input  logic clk,
   input  logic rst_main_n,
   input  logic sh_cl_flr_assert,
   output logic pipe_rst_n,
   output logic cl_sh_flr_done
);

   import ddr_stat_pkg::*;

   logic [RST_SYNC_STGS-1:0] rst_sync_q;
   logic                     flr_assert_q;

   //////////////////////////////////////////////////
   // Reset synchronizer
   //////////////////////////////////////////////////

   // Shift chain from rst_main_n to pipe_rst_n
   always_ff @(posedge clk)
   begin
      rst_sync_q <= {rst_sync_q[RST_SYNC_STGS-2:0], rst_main_n};
   end

   assign pipe_rst_n = rst_sync_q[RST_SYNC_STGS-1];

   //////////////////////////////////////////////////
   // Function-level reset response
   //////////////////////////////////////////////////

   // Done follows the registered assert, and drops every other cycle
   // while the assert stays high
   always_ff @(posedge clk)
   begin
      if (!pipe_rst_n)
      begin
         flr_assert_q   <= 1'b0;
         cl_sh_flr_done <= 1'b0;
      end
      else
      begin
         flr_assert_q   <= sh_cl_flr_assert;
         cl_sh_flr_done <= flr_assert_q && !cl_sh_flr_done;
      end
   end

   // Done answers an assert from two cycles back and never lasts two cycles
   done_is_pulse: assert property (
      @(posedge clk) disable iff (!pipe_rst_n)
      cl_sh_flr_done |-> $past(sh_cl_flr_assert, 2) && !$past(cl_sh_flr_done)
   )
   else
      $error("cl_sh_flr_done without an assert two cycles back, or high twice in a row");

endmodule

// ==== logic/ddr_stat_pkg.sv ====
// DDR status bridge definitions

package ddr_stat_pkg;

   //////////////////////////////////////////////////
   // Widths and depths
   //////////////////////////////////////////////////

   // Status channel field widths
   localparam int STAT_ADDR_W = 8;
   localparam int STAT_DATA_W = 32;
   localparam int STAT_INT_W  = 8;

   // Extra register stages on each side of the status target
   localparam int NUM_CFG_STGS = 8;

   // Flops between rst_main_n and pipe_rst_n
   localparam int RST_SYNC_STGS = 4;

   // Status register file size and its index width
   localparam int NUM_STAT_REGS = 16;
   localparam int STAT_IDX_W    = $clog2(NUM_STAT_REGS);

   //////////////////////////////////////////////////
   // Types
   //////////////////////////////////////////////////

   typedef logic [STAT_ADDR_W-1:0] stat_addr_t;
   typedef logic [STAT_DATA_W-1:0] stat_data_t;
   typedef logic [STAT_INT_W-1:0]  stat_int_t;

   // Host to target request, wr and rd are one-cycle strobes
   typedef struct packed {
      logic       wr;
      logic       rd;
      stat_addr_t addr;
      stat_data_t wdata;
   } stat_req_t;

   // Target to host response
   typedef struct packed {
      logic       ack;
      stat_int_t  intr;
      stat_data_t rdata;
   } stat_ack_t;

   // Flat widths used when the structs ride through a pipeline
   localparam int STAT_REQ_W = $bits(stat_req_t);
   localparam int STAT_ACK_W = $bits(stat_ack_t);

endpackage
